//--- hdl/tcdm_pkg.sv
`default_nettype none

// bus format shared by the banks and the splitter
package tcdm_pkg;

  // widths
  localparam int unsigned ADDR_W      = 32;  // byte address
  localparam int unsigned DATA_W      = 32;  // one bank word
  localparam int unsigned WIDE_DATA_W = 64;  // wide initiator port

  // memory map
  localparam int unsigned BANK_WORDS   = 256;
  localparam int unsigned BANK_SEL_BIT = 2;                 // word interleave bit
  localparam int unsigned BANK_IDX_LSB = BANK_SEL_BIT + 1;  // word index starts above it
  localparam int unsigned BANK_IDX_W   = $clog2(BANK_WORDS);

  // byte enable widths
  localparam int unsigned BE_W      = DATA_W / 8;
  localparam int unsigned WIDE_BE_W = WIDE_DATA_W / 8;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      word_t;
  typedef logic [WIDE_DATA_W-1:0] wide_word_t;
  typedef logic [BE_W-1:0]        be_t;
  typedef logic [WIDE_BE_W-1:0]   wide_be_t;

  // word index inside a bank, addr[10:3]
  typedef logic [BANK_IDX_W-1:0] bank_idx_t;

endpackage : tcdm_pkg

`default_nettype wire

//--- hdl/split_pkg.sv
`default_nettype none

// split control: channel count and grant tracking
package split_pkg;

  localparam int unsigned NB_CHAN    = 2;
  localparam int unsigned CHAN_BYTES = 4;  // address stride from one channel to the next

  typedef logic [NB_CHAN-1:0] chan_mask_t;  // one bit per channel

  typedef enum logic {
    GNT_PASS = 1'b0,  // requests go straight through
    GNT_HOLD = 1'b1   // part of the wide request still waits for a bank
  } gnt_state_e;

endpackage : split_pkg

`default_nettype wire

//--- hdl/split_req_issue.sv
`default_nettype none

// issues one wide request as NB_CHAN word requests, tracks partial grants
module split_req_issue
  import tcdm_pkg::*;
  import split_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  // wide initiator
  input  logic                  wide_req_i,
  input  addr_t                 wide_add_i,
  input  logic                  wide_wen_i,   // 1 = read
  input  wide_be_t              wide_be_i,
  input  wide_word_t            wide_data_i,
  output logic                  wide_gnt_o,
  // channels towards the banks
  output chan_mask_t            chan_req_o,
  output addr_t [NB_CHAN-1:0]   chan_add_o,
  output logic                  chan_wen_o,
  output be_t   [NB_CHAN-1:0]   chan_be_o,
  output word_t [NB_CHAN-1:0]   chan_data_o,
  input  chan_mask_t            chan_gnt_i
);

  gnt_state_e state_q, state_d;
  chan_mask_t done_q, done_d;  // channels already granted during hold
  chan_mask_t done_eff;        // mask only counts while holding

  assign done_eff = (state_q == GNT_HOLD) ? done_q : '0;

  // wide grant once every channel is granted now or was granted before
  assign wide_gnt_o = &(chan_gnt_i | done_eff);

  always_comb begin
    state_d = state_q;
    done_d  = done_q;
    unique case (state_q)
      GNT_PASS: begin
        if (wide_req_i && !wide_gnt_o) begin  // partial or no grant
          state_d = GNT_HOLD;
          done_d  = chan_gnt_i;                 // remember what got through
        end
      end
      GNT_HOLD: begin
        if (wide_gnt_o) begin  // last missing channels granted
          state_d = GNT_PASS;
          done_d  = '0;
        end else begin
          done_d = done_q | chan_gnt_i;
        end
      end
      default: begin
        state_d = GNT_PASS;
        done_d  = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GNT_PASS;
      done_q  <= '0;
    end else if (clear_i) begin
      state_q <= GNT_PASS;
      done_q  <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  assign chan_wen_o = wide_wen_i;  // same direction on every channel

  // per channel slicing, granted channels drop out while holding
  for (genvar i = 0; i < NB_CHAN; i++) begin : g_chan
    assign chan_req_o[i]  = wide_req_i & ~done_eff[i];
    assign chan_add_o[i]  = wide_add_i + addr_t'(i * CHAN_BYTES);
    assign chan_be_o[i]   = wide_be_i[i*BE_W +: BE_W];
    assign chan_data_o[i] = wide_data_i[i*DATA_W +: DATA_W];
  end

  // banks only grant requested channels, so no grant appears out of nothing
  a_gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) wide_gnt_o |-> wide_req_i
  );

endmodule : split_req_issue

`default_nettype wire

//--- hdl/split_resp_merge.sv
`default_nettype none

// collects the channel responses of one wide request into one wide response
module split_resp_merge
  import tcdm_pkg::*;
  import split_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  chan_mask_t            chan_r_valid_i,
  input  word_t [NB_CHAN-1:0]   chan_r_data_i,
  output logic                  wide_r_valid_o,
  output wide_word_t            wide_r_data_o
);

  chan_mask_t          got_q, got_d;  // channels that answered early
  word_t [NB_CHAN-1:0] data_q;        // their saved read data
  logic                all_here;

  // every channel answers now or has answered already
  assign all_here       = &(chan_r_valid_i | got_q);
  assign wide_r_valid_o = all_here;

  always_comb begin
    got_d = got_q | chan_r_valid_i;
    if (all_here) begin
      got_d = '0;  // merged, start over
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      got_q <= '0;
    end else if (clear_i) begin
      got_q <= '0;
    end else begin
      got_q <= got_d;
    end
  end

  // saved read words of early channels
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NB_CHAN; i++) begin
      if (chan_r_valid_i[i]) begin
        data_q[i] <= chan_r_data_i[i];
      end
    end
  end

  // saved word for early channels, live word otherwise
  for (genvar i = 0; i < NB_CHAN; i++) begin : g_data
    assign wide_r_data_o[i*DATA_W +: DATA_W] = got_q[i] ? data_q[i] : chan_r_data_i[i];
  end

  // issue masks granted channels, so a channel never answers twice per wide request
  a_no_double_resp : assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i) (chan_r_valid_i & got_q) == '0
  );

endmodule : split_resp_merge

`default_nettype wire

//--- hdl/tcdm_bank.sv
`default_nettype none

// one word wide bank, side port always wins, response one cycle after grant
module tcdm_bank
  import tcdm_pkg::*;
#(
  parameter int unsigned BANK_ID = 0  // value of addr[BANK_SEL_BIT] served here
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   clear_i,
  // wide channel
  input  logic   chan_req_i,
  input  addr_t  chan_add_i,
  input  logic   chan_wen_i,  // 1 = read
  input  be_t    chan_be_i,
  input  word_t  chan_data_i,
  output logic   chan_gnt_o,
  output logic   chan_r_valid_o,
  output word_t  chan_r_data_o,
  // side initiator
  input  logic   side_req_i,
  input  addr_t  side_add_i,
  input  logic   side_wen_i,
  input  be_t    side_be_i,
  input  word_t  side_data_i,
  output logic   side_r_valid_o,
  output word_t  side_r_data_o
);

  word_t     mem_q [BANK_WORDS];
  logic      side_sel;  // side request targets this bank
  logic      access;
  addr_t     acc_add;
  logic      acc_wen;
  be_t       acc_be;
  word_t     acc_data;
  bank_idx_t idx;
  logic      chan_valid_q, side_valid_q;  // response owner
  word_t     rdata_q;

  assign side_sel   = side_req_i & (side_add_i[BANK_SEL_BIT] == 1'(BANK_ID));
  assign chan_gnt_o = chan_req_i & ~side_sel;  // fixed priority
  assign access     = side_sel | chan_req_i;

  // winner mux
  assign acc_add  = side_sel ? side_add_i  : chan_add_i;
  assign acc_wen  = side_sel ? side_wen_i  : chan_wen_i;
  assign acc_be   = side_sel ? side_be_i   : chan_be_i;
  assign acc_data = side_sel ? side_data_i : chan_data_i;
  assign idx      = acc_add[BANK_IDX_LSB +: BANK_IDX_W];

  always_ff @(posedge clk_i) begin
    if (access && !acc_wen) begin  // byte enabled write
      for (int b = 0; b < BE_W; b++) begin
        if (acc_be[b]) mem_q[idx][8*b +: 8] <= acc_data[8*b +: 8];
      end
    end
    if (access && acc_wen) rdata_q <= mem_q[idx];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chan_valid_q <= 1'b0;
      side_valid_q <= 1'b0;
    end else if (clear_i) begin
      chan_valid_q <= 1'b0;
      side_valid_q <= 1'b0;
    end else begin
      chan_valid_q <= chan_gnt_o;  // writes answer too
      side_valid_q <= side_sel;
    end
  end

  assign chan_r_valid_o = chan_valid_q;
  assign chan_r_data_o  = rdata_q;
  assign side_r_valid_o = side_valid_q;
  assign side_r_data_o  = side_valid_q ? rdata_q : '0;  // zero so the top can OR banks

  a_one_resp : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(chan_r_valid_o && side_r_valid_o)
  );

  // splitter wiring must route each channel to its own bank
  a_chan_bank : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      chan_req_i |-> (chan_add_i[BANK_SEL_BIT] == 1'(BANK_ID))
  );

endmodule : tcdm_bank

`default_nettype wire

//--- hdl/tcdm_split_top.sv
`default_nettype none

// wide port split over two interleaved banks, narrow side port shares them
module tcdm_split_top
  import tcdm_pkg::*;
  import split_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  // wide initiator
  input  logic       wide_req_i,
  input  addr_t      wide_add_i,
  input  logic       wide_wen_i,
  input  wide_be_t   wide_be_i,
  input  wide_word_t wide_data_i,
  output logic       wide_gnt_o,
  output logic       wide_r_valid_o,
  output wide_word_t wide_r_data_o,
  // side initiator, never refused
  input  logic       side_req_i,
  input  addr_t      side_add_i,
  input  logic       side_wen_i,
  input  be_t        side_be_i,
  input  word_t      side_data_i,
  output logic       side_r_valid_o,
  output word_t      side_r_data_o
);

  chan_mask_t          chan_req, chan_gnt, chan_r_valid;
  addr_t [NB_CHAN-1:0] chan_add;
  logic                chan_wen;
  be_t   [NB_CHAN-1:0] chan_be;
  word_t [NB_CHAN-1:0] chan_data, chan_r_data;
  chan_mask_t          side_r_valid;  // per bank
  word_t [NB_CHAN-1:0] side_r_data;

  split_req_issue u_issue (
    .clk_i, .rst_ni, .clear_i,
    .wide_req_i, .wide_add_i, .wide_wen_i, .wide_be_i, .wide_data_i, .wide_gnt_o,
    .chan_req_o  (chan_req),
    .chan_add_o  (chan_add),
    .chan_wen_o  (chan_wen),
    .chan_be_o   (chan_be),
    .chan_data_o (chan_data),
    .chan_gnt_i  (chan_gnt)
  );

  // channel i lands on bank i
  for (genvar i = 0; i < NB_CHAN; i++) begin : g_bank
    tcdm_bank #(.BANK_ID(i)) u_bank (
      .clk_i, .rst_ni, .clear_i,
      .chan_req_i     (chan_req[i]),
      .chan_add_i     (chan_add[i]),
      .chan_wen_i     (chan_wen),
      .chan_be_i      (chan_be[i]),
      .chan_data_i    (chan_data[i]),
      .chan_gnt_o     (chan_gnt[i]),
      .chan_r_valid_o (chan_r_valid[i]),
      .chan_r_data_o  (chan_r_data[i]),
      .side_req_i, .side_add_i, .side_wen_i, .side_be_i, .side_data_i,
      .side_r_valid_o (side_r_valid[i]),
      .side_r_data_o  (side_r_data[i])
    );
  end

  split_resp_merge u_merge (
    .clk_i, .rst_ni, .clear_i,
    .chan_r_valid_i (chan_r_valid),
    .chan_r_data_i  (chan_r_data),
    .wide_r_valid_o, .wide_r_data_o
  );

  // only the addressed bank answers, idle bank data is zero
  assign side_r_valid_o = |side_r_valid;
  assign side_r_data_o  = side_r_data[0] | side_r_data[1];

endmodule : tcdm_split_top

`default_nettype wire

//--- testbench/tb_tcdm_split.sv
`default_nettype none

module tb_tcdm_split
  import tcdm_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TMO = 50;  // cycles per wait

  logic clk_i = 1'b0, rst_ni, clear_i;
  logic wide_req_i, wide_wen_i, wide_gnt_o, wide_r_valid_o;
  addr_t wide_add_i, side_add_i;
  wide_be_t wide_be_i;
  wide_word_t wide_data_i, wide_r_data_o;
  logic side_req_i, side_wen_i, side_r_valid_o;
  be_t side_be_i;
  word_t side_data_i, side_r_data_o;

  logic [7:0] ref_mem [2048];  // byte address bits 10:0, bank and word follow from them
  int errors = 0, passes = 0, gnt_cnt = 0, rv_cnt = 0;
  int gw, rw;  // grant and response latency of the last wide op
  wide_word_t rd;

  always #20 clk_i = ~clk_i;

  tcdm_split_top u_tcdm_split_top (.*);

  always @(negedge clk_i) if (rst_ni && wide_r_valid_o) rv_cnt++;

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, act, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  function automatic wide_word_t ref_wide(input addr_t a);
    wide_word_t r;
    for (int b = 0; b < 8; b++) r[8*b +: 8] = ref_mem[(a + b) & 11'h7ff];
    return r;
  endfunction

  // called at a falling edge, returns at the falling edge that shows the merged response
  task automatic wide_op(input logic rdn, input addr_t a, input wide_be_t be,
                         input wide_word_t d);
    wide_word_t exp;
    {wide_req_i, wide_wen_i, wide_add_i, wide_be_i, wide_data_i} = {1'b1, rdn, a, be, d};
    gw = 0;
    #1;
    while (!wide_gnt_o && gw < TMO) begin
      @(negedge clk_i);
      #1;
      gw++;
    end
    if (!wide_gnt_o) begin
      $display("wide grant never came for address %h", a);
      errors++;
    end
    gnt_cnt++;
    exp = ref_wide(a);
    if (!rdn) for (int b = 0; b < 8; b++) if (be[b]) ref_mem[(a + b) & 11'h7ff] = d[8*b +: 8];
    rw = 0;
    do begin
      @(negedge clk_i);
      wide_req_i = 1'b0;
      rw++;
    end while (!wide_r_valid_o && rw < TMO);
    if (!wide_r_valid_o) begin
      $display("wide response never came for address %h", a);
      errors++;
    end else if (rdn) begin
      check("wide_r_data_o", wide_r_data_o, exp);
    end
    rd = wide_r_data_o;
  endtask

  // side request accepted in the current cycle, response sampled one cycle on
  task automatic side_op(input logic rdn, input addr_t a, input be_t be, input word_t d);
    word_t exp;
    {side_req_i, side_wen_i, side_add_i, side_be_i, side_data_i} = {1'b1, rdn, a, be, d};
    for (int b = 0; b < 4; b++) exp[8*b +: 8] = ref_mem[(a + b) & 11'h7ff];
    if (!rdn) for (int b = 0; b < 4; b++) if (be[b]) ref_mem[(a + b) & 11'h7ff] = d[8*b +: 8];
    @(negedge clk_i);
    side_req_i = 1'b0;
    check("side_r_valid_o", side_r_valid_o, 1'b1);
    if (rdn) check("side_r_data_o", side_r_data_o, exp);
  endtask

  task automatic report(input string name, input int err0);
    $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic basic_write_read();
    int e0 = errors;
    @(negedge clk_i);
    wide_op(1'b0, 32'h40, 8'b1011_1101, 64'h1122_3344_5566_7788);
    check("grant wait", gw, 0);
    check("response wait", rw, 1);
    wide_op(1'b1, 32'h40, 8'hff, '0);
    check("grant wait", gw, 0);
    check("response wait", rw, 1);
    report("uncontested write and read", e0);
  endtask

  task automatic side_write_wide_read();
    int e0 = errors;
    @(negedge clk_i);
    side_op(1'b0, 32'h104, 4'hf, 32'hcafe_f00d);  // bit 2 set, so bank 1
    wide_op(1'b1, 32'h100, 8'hff, '0);
    check("wide_r_data_o upper", rd[63:32], 32'hcafe_f00d);
    report("side write then wide read", e0);
  endtask

  task automatic stalled_wide_read();
    int e0 = errors;
    int rv0;
    @(negedge clk_i);
    rv0 = rv_cnt;  // earlier responses are counted by now
    fork
      wide_op(1'b1, 32'h40, 8'hff, '0);
      repeat (3) side_op(1'b1, 32'h204, 4'hf, '0);
    join
    check("grant wait", gw, 3);
    repeat (3) @(negedge clk_i);
    check("wide_r_valid_o pulses", rv_cnt - rv0, 1);
    report("stalled wide read", e0);
  endtask

  task automatic staggered_conflicts();
    int e0 = errors;
    @(negedge clk_i);
    fork
      wide_op(1'b0, 32'h80, 8'hff, 64'h0f1e_2d3c_4b5a_6978);
      begin
        repeat (2) side_op(1'b0, 32'h300, 4'h3, 32'h0000_aaaa);
        repeat (2) side_op(1'b0, 32'h304, 4'hc, 32'h5555_0000);
      end
    join
    // channel 1 got through first and stays masked once side moves to bank 1
    check("grant wait", gw, 2);
    wide_op(1'b1, 32'h80, 8'hff, '0);
    wide_op(1'b1, 32'h300, 8'hff, '0);
    report("staggered conflicts", e0);
  endtask

  // wide traffic stays below 0x400, concurrent side noise above it
  task automatic random_traffic();
    int e0 = errors;
    int g0 = gnt_cnt;
    int rv0;
    @(negedge clk_i);
    rv0 = rv_cnt;
    for (int n = 0; n < 200; n++) begin
      if ($urandom_range(0, 2) != 0) begin
        fork
          wide_op($urandom_range(0, 1), addr_t'($urandom_range(0, 127) * 8),
                  wide_be_t'($urandom), {$urandom, $urandom});
          repeat ($urandom_range(0, 3))
            side_op($urandom_range(0, 1), addr_t'(1024 + $urandom_range(0, 255) * 4),
                    be_t'($urandom), word_t'($urandom));
        join
      end else begin
        side_op($urandom_range(0, 1), addr_t'($urandom_range(0, 511) * 4),
                be_t'($urandom), word_t'($urandom));
      end
    end
    repeat (2) @(negedge clk_i);
    check("wide_r_valid_o count", rv_cnt - rv0, gnt_cnt - g0);
    report("random traffic", e0);
  endtask

  task automatic clear_during_stall();
    int e0 = errors;
    int rv0;
    @(negedge clk_i);
    rv0 = rv_cnt;
    {wide_req_i, wide_wen_i, wide_add_i, wide_be_i} = {1'b1, 1'b1, 32'h48, 8'hff};
    {side_req_i, side_wen_i, side_add_i} = {1'b1, 1'b1, 32'h200};  // holds bank 0
    repeat (2) @(negedge clk_i);
    {clear_i, wide_req_i, side_req_i} = 3'b100;
    @(negedge clk_i);
    clear_i = 1'b0;
    repeat (4) @(negedge clk_i);
    check("wide_r_valid_o after clear", rv_cnt - rv0, 0);
    basic_write_read();
    report("clear during stall", e0);
  endtask

  initial begin
    void'($urandom(12624));
    {rst_ni, clear_i, wide_req_i, wide_wen_i, side_req_i, side_wen_i} = 6'b0;
    {wide_add_i, wide_be_i, wide_data_i} = '0;
    {side_add_i, side_be_i, side_data_i} = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    basic_write_read();
    side_write_wide_read();
    stalled_wide_read();
    staggered_conflicts();
    random_traffic();
    clear_during_stall();
    $display("checks: %0d passed, %0d failed, %0d wide grants", passes, errors, gnt_cnt);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_tcdm_split

`default_nettype wire

//--- files.f
hdl/tcdm_pkg.sv
hdl/split_pkg.sv
hdl/split_req_issue.sv
hdl/split_resp_merge.sv
hdl/tcdm_bank.sv
hdl/tcdm_split_top.sv
testbench/tb_tcdm_split.sv

//--- Bender.yml
package:
  name: tcdm_split

sources:
  - hdl/tcdm_pkg.sv
  - hdl/split_pkg.sv
  - hdl/split_req_issue.sv
  - hdl/split_resp_merge.sv
  - hdl/tcdm_bank.sv
  - hdl/tcdm_split_top.sv
  - target: test
    files:
      - testbench/tb_tcdm_split.sv
